// ==== logic/rob_cfg_pkg.sv ====
// ************************************************************
// sizes shared by every stage of the rename and ROB pipeline
// ************************************************************
`default_nettype none

package rob_cfg_pkg;
    // dispatch and retire lanes per cycle
    localparam int n_ways = 2;
    localparam int rob_depth = 8;
    localparam int arch_regs = 32;
    // power of two, the free list pointers wrap on it
    localparam int phys_regs = 64;

    localparam int rob_idx_w = $clog2(rob_depth);
    localparam int arch_w = $clog2(arch_regs);
    localparam int tag_w = $clog2(phys_regs);
    // counts that include their upper bound
    localparam int free_count_w = $clog2(phys_regs + 1);
    localparam int rob_cnt_w = $clog2(rob_depth + 1);
    localparam int lane_cnt_w = $clog2(n_ways + 1);
endpackage

`default_nettype wire

// ==== logic/rob_types_pkg.sv ====
// ************************************************************
// packets passed between rename, ROB, retire and free list
// ************************************************************
`default_nettype none

package rob_types_pkg;
    import rob_cfg_pkg::*;

    typedef enum logic [1:0] {
        op_alu,
        op_load,
        op_store,
        op_branch
    } op_class_e;

    typedef struct packed {
        logic valid;
        op_class_e op;
        logic [arch_w-1:0] dest;
    } dispatch_packet_t;

    // t is the new tag, t_old the tag it displaces in the map
    typedef struct packed {
        logic valid;
        logic complete;
        op_class_e op;
        logic [arch_w-1:0] dest;
        logic [tag_w-1:0] t;
        logic [tag_w-1:0] t_old;
    } rob_entry_t;

    typedef struct packed {
        logic valid;
        logic [tag_w-1:0] tag;
    } cdb_packet_t;

    typedef struct packed {
        logic valid;
        op_class_e op;
        logic [arch_w-1:0] dest;
        logic [tag_w-1:0] t;
        logic [tag_w-1:0] t_old;
    } retire_packet_t;

    typedef struct packed {
        logic we;
        logic [arch_w-1:0] arch;
        logic [tag_w-1:0] tag;
    } map_write_t;

    typedef struct packed {
        logic valid;
        logic [tag_w-1:0] tag;
    } free_push_t;

    // only alu and load results land in a register
    function automatic logic writes_dest(op_class_e op);
        return (op == op_alu) || (op == op_load);
    endfunction
endpackage

`default_nettype wire

// ==== logic/free_list.sv ====
// ************************************************************
// queue of free physical tags, popped at rename, pushed at retire
// ************************************************************
`default_nettype none

module free_list import rob_cfg_pkg::*, rob_types_pkg::*; (
    input wire logic clock,
    input wire logic reset,
    input wire logic [lane_cnt_w-1:0] pop_count,
    output logic [n_ways-1:0][tag_w-1:0] free_tags,
    output logic [free_count_w-1:0] free_count,
    input free_push_t [n_ways-1:0] push
);
    logic [tag_w-1:0] queue [phys_regs];
    // pointers wrap at phys_regs by width alone
    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    logic [lane_cnt_w-1:0] push_cnt;
    logic [n_ways-1:0][lane_cnt_w-1:0] push_ofs;

    // oldest n_ways tags, rename takes a prefix of them
    always_comb begin
        for (int i = 0; i < n_ways; i++) begin
            free_tags[i] = queue[head + tag_w'(i)];
        end
    end

    // freed tags go in back to back even if lanes skip a push
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < n_ways; i++) begin
            push_ofs[i] = push_cnt;
            if (push[i].valid) push_cnt = push_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // slots 0..31 hold tags 32..63, the rest are unused
            for (int i = 0; i < phys_regs; i++) begin
                queue[i] <= tag_w'(arch_regs + i);
            end
            head <= '0;
            tail <= tag_w'(phys_regs - arch_regs);
            free_count <= free_count_w'(phys_regs - arch_regs);
        end else begin
            for (int i = 0; i < n_ways; i++) begin
                if (push[i].valid) queue[tail + tag_w'(push_ofs[i])] <= push[i].tag;
            end
            head <= head + tag_w'(pop_count);
            tail <= tail + tag_w'(push_cnt);
            free_count <= free_count - free_count_w'(pop_count) + free_count_w'(push_cnt);
        end
    end

    // rename must size its pop from the count it was given
    a_no_underflow: assert property (@(posedge clock) disable iff (reset)
        free_count_w'(pop_count) <= free_count);

endmodule

`default_nettype wire

// ==== logic/map_table.sv ====
// ************************************************************
// speculative arch to phys map, read old tags then write new
// ************************************************************
`default_nettype none

module map_table import rob_cfg_pkg::*, rob_types_pkg::*; (
    input wire logic clock,
    input wire logic reset,
    input wire logic [n_ways-1:0][arch_w-1:0] read_arch,
    output logic [n_ways-1:0][tag_w-1:0] read_tag,
    input map_write_t [n_ways-1:0] write
);
    logic [tag_w-1:0] tag_map [arch_regs];

    // reads see the map as it stood before this edge
    always_comb begin
        for (int i = 0; i < n_ways; i++) begin
            read_tag[i] = tag_map[read_arch[i]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // arch r starts on phys r
            for (int r = 0; r < arch_regs; r++) begin
                tag_map[r] <= tag_w'(r);
            end
        end else begin
            // later lane is younger and must win on equal arch
            for (int i = 0; i < n_ways; i++) begin
                if (write[i].we) tag_map[write[i].arch] <= write[i].tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/rename_stage.sv ====
// ************************************************************
// accepts dispatch lanes, renames dests, registers ROB entries
// ************************************************************
`default_nettype none

module rename_stage import rob_cfg_pkg::*, rob_types_pkg::*; (
    input wire logic clock,
    input wire logic reset,
    input dispatch_packet_t [n_ways-1:0] dispatch,
    output logic [lane_cnt_w-1:0] dispatch_slots,
    input wire logic [n_ways-1:0][tag_w-1:0] free_tags,
    input wire logic [free_count_w-1:0] free_count,
    output logic [lane_cnt_w-1:0] pop_count,
    output logic [n_ways-1:0][arch_w-1:0] map_read_arch,
    input wire logic [n_ways-1:0][tag_w-1:0] map_read_tag,
    output map_write_t [n_ways-1:0] map_write,
    input wire logic [rob_cnt_w-1:0] rob_open,
    output rob_entry_t [n_ways-1:0] rob_write
);
    logic [free_count_w-1:0] slots_wide;
    logic [lane_cnt_w-1:0] valid_cnt;
    logic [lane_cnt_w-1:0] accept_cnt;
    logic lanes_contiguous;
    rob_entry_t [n_ways-1:0] next_entry;

    // slots = min(n_ways, open ROB entries, free tags)
    always_comb begin
        slots_wide = free_count_w'(n_ways);
        if (free_count_w'(rob_open) < slots_wide) slots_wide = free_count_w'(rob_open);
        if (free_count < slots_wide) slots_wide = free_count;
    end
    assign dispatch_slots = lane_cnt_w'(slots_wide);

    always_comb begin
        valid_cnt = '0;
        lanes_contiguous = 1'b1;
        for (int i = 0; i < n_ways; i++) begin
            if (dispatch[i].valid) valid_cnt = valid_cnt + 1'b1;
            if (i > 0 && dispatch[i].valid && !dispatch[i-1].valid) lanes_contiguous = 1'b0;
            map_read_arch[i] = dispatch[i].dest;
        end
    end
    // lanes past the accepted count are offered again
    assign accept_cnt = (valid_cnt < dispatch_slots) ? valid_cnt : dispatch_slots;

    always_comb begin
        logic [lane_cnt_w-1:0] alloc;
        logic [tag_w-1:0] old_tag;
        logic accept;
        logic writes;
        alloc = '0;
        for (int i = 0; i < n_ways; i++) begin
            accept = lane_cnt_w'(i) < accept_cnt;
            writes = accept && writes_dest(dispatch[i].op);
            // youngest earlier lane with the same dest supplies t_old
            old_tag = map_read_tag[i];
            for (int j = 0; j < i; j++) begin
                if (map_write[j].we && map_write[j].arch == dispatch[i].dest) begin
                    old_tag = map_write[j].tag;
                end
            end
            // free tags are handed out in order to dest writers only
            map_write[i] = '{we: writes, arch: dispatch[i].dest, tag: free_tags[alloc]};
            next_entry[i] = '0;
            if (accept) begin
                next_entry[i].valid = 1'b1;
                next_entry[i].op = dispatch[i].op;
                next_entry[i].dest = dispatch[i].dest;
                if (writes) begin
                    next_entry[i].t = free_tags[alloc];
                    next_entry[i].t_old = old_tag;
                end else begin
                    // stores and branches get no tag, nothing will complete them
                    next_entry[i].complete = 1'b1;
                end
            end
            if (writes) alloc = alloc + 1'b1;
        end
        pop_count = alloc;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rob_write <= '0;
        end else begin
            rob_write <= next_entry;
        end
    end

    // tag and slot handout assumes lanes fill from lane 0
    a_lanes_contiguous: assert property (@(posedge clock) disable iff (reset)
        lanes_contiguous);

endmodule

`default_nettype wire

// ==== logic/rob.sv ====
// ************************************************************
// circular reorder buffer, tail writes, cdb completion, head pops
// ************************************************************
`default_nettype none

module rob import rob_cfg_pkg::*, rob_types_pkg::*; (
    input wire logic clock,
    input wire logic reset,
    input rob_entry_t [n_ways-1:0] write,
    input cdb_packet_t [n_ways-1:0] cdb,
    output logic [rob_cnt_w-1:0] open_entries,
    output rob_entry_t [n_ways-1:0] head_entries
);
    rob_entry_t [rob_depth-1:0] entries;
    logic [rob_idx_w-1:0] head;
    logic [rob_idx_w-1:0] tail;
    logic [rob_cnt_w-1:0] count;
    logic [lane_cnt_w-1:0] pop_cnt;
    logic [lane_cnt_w-1:0] wr_cnt;
    // stored entries in the low bits, entries being written above them
    logic [n_ways-1:0][rob_depth+n_ways-1:0] hit_vec;
    logic [rob_depth+n_ways-1:0] hit_any;

    function automatic logic tag_hit(rob_entry_t e, cdb_packet_t c);
        return e.valid && !e.complete && c.valid && (e.t == c.tag);
    endfunction

    // longest run of complete entries from the head, up to n_ways
    always_comb begin
        logic run;
        logic [rob_idx_w-1:0] idx;
        run = 1'b1;
        pop_cnt = '0;
        head_entries = '0;
        for (int i = 0; i < n_ways; i++) begin
            idx = head + rob_idx_w'(i);
            run = run && entries[idx].valid && entries[idx].complete;
            if (run) begin
                head_entries[i] = entries[idx];
                pop_cnt = pop_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        wr_cnt = '0;
        for (int w = 0; w < n_ways; w++) begin
            if (write[w].valid) wr_cnt = wr_cnt + 1'b1;
        end
    end
    // the rename register already owns wr_cnt of the open slots
    assign open_entries = rob_cnt_w'(rob_depth) - count - rob_cnt_w'(wr_cnt);

    // match every cdb lane against stored and incoming entries
    always_comb begin
        hit_any = '0;
        for (int k = 0; k < n_ways; k++) begin
            for (int e = 0; e < rob_depth; e++) begin
                hit_vec[k][e] = tag_hit(entries[e], cdb[k]);
            end
            for (int w = 0; w < n_ways; w++) begin
                hit_vec[k][rob_depth+w] = tag_hit(write[w], cdb[k]);
            end
            hit_any = hit_any | hit_vec[k];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            for (int e = 0; e < rob_depth; e++) begin
                if (hit_any[e]) entries[e].complete <= 1'b1;
            end
            // retire first, the freed slots are never the tail slots here
            for (int i = 0; i < n_ways; i++) begin
                if (i < int'(pop_cnt)) entries[head + rob_idx_w'(i)].valid <= 1'b0;
            end
            for (int w = 0; w < n_ways; w++) begin
                if (write[w].valid) begin
                    entries[tail + rob_idx_w'(w)] <= write[w];
                    if (hit_any[rob_depth+w]) entries[tail + rob_idx_w'(w)].complete <= 1'b1;
                end
            end
            head <= head + rob_idx_w'(pop_cnt);
            tail <= tail + rob_idx_w'(wr_cnt);
            count <= count - rob_cnt_w'(pop_cnt) + rob_cnt_w'(wr_cnt);
        end
    end

    // a live tag sits in at most one in-flight entry
    for (genvar k = 0; k < n_ways; k++) begin : g_cdb_check
        a_single_hit: assert property (@(posedge clock) disable iff (reset)
            $onehot0(hit_vec[k]));
    end

    // rename only sends what the reported open count allowed
    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        count + rob_cnt_w'(wr_cnt) <= rob_cnt_w'(rob_depth));

endmodule

`default_nettype wire

// ==== logic/retire_stage.sv ====
// ************************************************************
// registers the retired group, commits the map, frees old tags
// ************************************************************
`default_nettype none

module retire_stage import rob_cfg_pkg::*, rob_types_pkg::*; (
    input wire logic clock,
    input wire logic reset,
    input rob_entry_t [n_ways-1:0] head_entries,
    output retire_packet_t [n_ways-1:0] retire,
    output free_push_t [n_ways-1:0] free_push
);
    // committed arch to phys map
    logic [tag_w-1:0] arch_map [arch_regs];
    logic [n_ways-1:0] old_tag_ok;

    // t_old must be what the committed map held, after older lanes of the group
    always_comb begin
        logic [tag_w-1:0] expect_old;
        for (int i = 0; i < n_ways; i++) begin
            expect_old = arch_map[head_entries[i].dest];
            for (int j = 0; j < i; j++) begin
                if (head_entries[j].valid && writes_dest(head_entries[j].op) &&
                    head_entries[j].dest == head_entries[i].dest) begin
                    expect_old = head_entries[j].t;
                end
            end
            old_tag_ok[i] = !(head_entries[i].valid && writes_dest(head_entries[i].op)) ||
                            (head_entries[i].t_old == expect_old);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            retire <= '0;
            for (int r = 0; r < arch_regs; r++) begin
                arch_map[r] <= tag_w'(r);
            end
        end else begin
            for (int i = 0; i < n_ways; i++) begin
                retire[i] <= '{valid: head_entries[i].valid, op: head_entries[i].op,
                               dest: head_entries[i].dest, t: head_entries[i].t,
                               t_old: head_entries[i].t_old};
                if (head_entries[i].valid && writes_dest(head_entries[i].op)) begin
                    arch_map[head_entries[i].dest] <= head_entries[i].t;
                end
            end
        end
    end

    // old tags return to the free list on the following edge
    always_comb begin
        for (int i = 0; i < n_ways; i++) begin
            free_push[i].valid = retire[i].valid && writes_dest(retire[i].op);
            free_push[i].tag = retire[i].t_old;
        end
    end

    a_old_tag_match: assert property (@(posedge clock) disable iff (reset) &old_tag_ok);

endmodule

`default_nettype wire

// ==== logic/rob_top.sv ====
// ************************************************************
// two-wide rename, ROB and retire; dispatch in, cdb in, retire out
// ************************************************************
`default_nettype none

module rob_top import rob_cfg_pkg::*, rob_types_pkg::*; (
    input wire logic clock,
    input wire logic reset,
    input dispatch_packet_t [n_ways-1:0] dispatch,
    output logic [lane_cnt_w-1:0] dispatch_slots,
    input cdb_packet_t [n_ways-1:0] cdb,
    output retire_packet_t [n_ways-1:0] retire
);
    logic [n_ways-1:0][tag_w-1:0] free_tags;
    logic [free_count_w-1:0] free_count;
    logic [lane_cnt_w-1:0] pop_count;
    logic [n_ways-1:0][arch_w-1:0] map_read_arch;
    logic [n_ways-1:0][tag_w-1:0] map_read_tag;
    map_write_t [n_ways-1:0] map_write;
    logic [rob_cnt_w-1:0] rob_open;
    rob_entry_t [n_ways-1:0] rob_write;
    rob_entry_t [n_ways-1:0] head_entries;
    free_push_t [n_ways-1:0] free_push;

    rename_stage u_rename (
        .clock(clock), .reset(reset),
        .dispatch(dispatch), .dispatch_slots(dispatch_slots),
        .free_tags(free_tags), .free_count(free_count), .pop_count(pop_count),
        .map_read_arch(map_read_arch), .map_read_tag(map_read_tag), .map_write(map_write),
        .rob_open(rob_open), .rob_write(rob_write)
    );

    free_list u_free_list (
        .clock(clock), .reset(reset),
        .pop_count(pop_count), .free_tags(free_tags), .free_count(free_count),
        .push(free_push)
    );

    map_table u_map_table (
        .clock(clock), .reset(reset),
        .read_arch(map_read_arch), .read_tag(map_read_tag), .write(map_write)
    );

    rob u_rob (
        .clock(clock), .reset(reset),
        .write(rob_write), .cdb(cdb),
        .open_entries(rob_open), .head_entries(head_entries)
    );

    retire_stage u_retire (
        .clock(clock), .reset(reset),
        .head_entries(head_entries), .retire(retire), .free_push(free_push)
    );

endmodule

`default_nettype wire

// ==== dv/rob_tb.sv ====
// ************************************************************
// random two-wide dispatch checked against a rename model
// ************************************************************
`default_nettype none

module rob_tb import rob_cfg_pkg::*, rob_types_pkg::*; ();
    localparam int clk_period = 8;
    localparam int reset_cycles = 4;
    localparam int n_instr = 400;
    // loose bound, completion holds take 15 of every 50 cycles
    localparam int max_cpi = 16;
    localparam int watchdog_time = clk_period * (reset_cycles + n_instr * max_cpi);

    logic clock;
    logic reset;
    dispatch_packet_t [n_ways-1:0] dispatch;
    logic [lane_cnt_w-1:0] dispatch_slots;
    cdb_packet_t [n_ways-1:0] cdb;
    retire_packet_t [n_ways-1:0] retire;

    logic [31:0] lfsr_state;
    // model of the free tag queue and the speculative map
    int free_q[$];
    logic [tag_w-1:0] spec_map [arch_regs];
    // committed map rebuilt from what the DUT retires
    logic [tag_w-1:0] seen_map [arch_regs];
    retire_packet_t scoreboard[$];
    // tags waiting on the stand-in execution, with the earliest cycle to complete
    int pend_tag[$];
    int pend_ready[$];
    int cyc;
    int issued;
    int retired;
    int in_flight;
    int slots_seen;
    int fail_count;

    rob_top u_dut (
        .clock(clock),
        .reset(reset),
        .dispatch(dispatch),
        .dispatch_slots(dispatch_slots),
        .cdb(cdb),
        .retire(retire)
    );

    initial clock = 1'b0;
    always #(clk_period / 2) clock = ~clock;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic int take_bits(input int n);
        int v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    function automatic void reset_model();
        free_q.delete();
        for (int t = arch_regs; t < phys_regs; t++) begin
            free_q.push_back(t);
        end
        for (int r = 0; r < arch_regs; r++) begin
            spec_map[r] = tag_w'(r);
            seen_map[r] = tag_w'(r);
        end
    endfunction

    // next instruction in program order; only alu and load take a tag
    function automatic retire_packet_t rob_ref_rename(input op_class_e op,
                                                      input logic [arch_w-1:0] dest);
        retire_packet_t p;
        p = '0;
        p.valid = 1'b1;
        p.op = op;
        p.dest = dest;
        if (op == op_alu || op == op_load) begin
            p.t = tag_w'(free_q.pop_front());
            p.t_old = spec_map[dest];
            spec_map[dest] = p.t;
        end
        return p;
    endfunction

    task automatic mismatch_stop(input string test_name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        fail_count++;
        $display("error %s: expected %0h, actual %0h", test_name, expected, actual);
        $display("Checks failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abort_with_reason(input string reason);
        fail_count++;
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "stopped at the first failure");
    endtask

    // what the DUT took at this edge, from the slots seen before it
    task automatic book_accepted();
        retire_packet_t pred;
        int nvalid;
        int n_acc;
        nvalid = 0;
        for (int i = 0; i < n_ways; i++) begin
            if (dispatch[i].valid) nvalid++;
        end
        n_acc = (nvalid < slots_seen) ? nvalid : slots_seen;
        for (int i = 0; i < n_acc; i++) begin
            pred = rob_ref_rename(dispatch[i].op, dispatch[i].dest);
            scoreboard.push_back(pred);
            in_flight++;
            if (pred.op == op_alu || pred.op == op_load) begin
                pend_tag.push_back(int'(pred.t));
                pend_ready.push_back(cyc + 2);
            end
        end
        // lanes past the accepted count move down and stay offered
        for (int i = 0; i < n_ways; i++) begin
            if (i + n_acc < n_ways) dispatch[i] = dispatch[i + n_acc];
            else dispatch[i] = '0;
        end
    endtask

    task automatic offer_next_group();
        int n;
        if (!dispatch[0].valid && issued < n_instr) begin
            n = take_bits(2);
            if (n > n_ways) n = n_ways;
            if (n > n_instr - issued) n = n_instr - issued;
            for (int i = 0; i < n; i++) begin
                dispatch[i].valid = 1'b1;
                dispatch[i].op = op_class_e'(take_bits(2));
                // a narrow dest range half the time gives same-dest pairs
                if (take_bits(1) == 1) dispatch[i].dest = arch_w'(take_bits(2));
                else dispatch[i].dest = arch_w'(take_bits(arch_w));
            end
            issued += n;
        end
    endtask

    // stand-in for execution, ready tags finish in shuffled order
    task automatic drive_completions();
        int n_ready;
        int pick;
        cdb = '0;
        // hold phase lets the ROB fill up
        if ((cyc % 50) < 35) begin
            for (int k = 0; k < n_ways; k++) begin
                n_ready = 0;
                while (n_ready < pend_ready.size() && pend_ready[n_ready] <= cyc) begin
                    n_ready++;
                end
                if (n_ready > 0 && take_bits(2) != 0) begin
                    pick = take_bits(3) % n_ready;
                    cdb[k].valid = 1'b1;
                    cdb[k].tag = tag_w'(pend_tag[pick]);
                    pend_tag.delete(pick);
                    pend_ready.delete(pick);
                end
            end
        end
    endtask

    task automatic compare_outputs();
        retire_packet_t expected_pkt;
        int exp_slots;
        int freed[$];
        for (int i = 1; i < n_ways; i++) begin
            assert (!retire[i].valid || retire[i-1].valid)
            else abort_with_reason("retire lanes are not contiguous from lane 0");
        end
        for (int i = 0; i < n_ways; i++) begin
            if (retire[i].valid) begin
                assert (scoreboard.size() > 0)
                else abort_with_reason("a retire lane is valid with nothing outstanding");
                expected_pkt = scoreboard.pop_front();
                assert (retire[i] == expected_pkt)
                else mismatch_stop($sformatf("retire of instruction %0d", retired),
                                   expected_pkt, retire[i]);
                retired++;
                in_flight--;
                if (retire[i].op == op_alu || retire[i].op == op_load) begin
                    seen_map[retire[i].dest] = retire[i].t;
                    freed.push_back(int'(retire[i].t_old));
                end
            end
        end
        // ROB space is back at the retire edge, old tags one edge later
        exp_slots = n_ways;
        if (rob_depth - in_flight < exp_slots) exp_slots = rob_depth - in_flight;
        if (free_q.size() < exp_slots) exp_slots = free_q.size();
        assert (int'(dispatch_slots) == exp_slots)
        else mismatch_stop("dispatch slots", exp_slots, dispatch_slots);
        slots_seen = int'(dispatch_slots);
        foreach (freed[k]) begin
            free_q.push_back(freed[k]);
        end
    endtask

    initial begin : stimulus
        lfsr_state = 32'hc9b4;
        reset = 1'b1;
        dispatch = '0;
        cdb = '0;
        cyc = 0;
        issued = 0;
        retired = 0;
        in_flight = 0;
        slots_seen = 0;
        fail_count = 0;
        reset_model();
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
        while (retired < n_instr) begin
            @(posedge clock);
            cyc++;
            #1;
            book_accepted();
            offer_next_group();
            drive_completions();
        end
        // last committed mapping of every arch reg
        for (int r = 0; r < arch_regs; r++) begin
            assert (seen_map[r] == spec_map[r])
            else mismatch_stop($sformatf("final map of r%0d", r), spec_map[r], seen_map[r]);
        end
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // outputs are settled mid cycle, inputs move just after the edge
    initial begin : comparator
        forever begin
            @(negedge clock);
            if (!reset) compare_outputs();
        end
    end

    initial begin : watchdog
        #(watchdog_time);
        fail_count++;
        $display("Checks failed");
        $fatal(1, "watchdog expired before all instructions retired");
    end

endmodule

`default_nettype wire

// ==== r10k_rob.f ====
logic/rob_cfg_pkg.sv
logic/rob_types_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/rename_stage.sv
logic/rob.sv
logic/retire_stage.sv
logic/rob_top.sv
dv/rob_tb.sv

// ==== Makefile ====
SIM := obj_dir/rob_sim
SRCS := $(shell cat r10k_rob.f)

.PHONY: all run clean

all: run

$(SIM): r10k_rob.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f r10k_rob.f --top-module rob_tb -o rob_sim

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
